/* logic/wb_bus_pkg.sv */
package wb_bus_pkg;

  // --------------------------------------------------
  // Host bus widths
  // --------------------------------------------------

  // Application address, word granular
  localparam int APP_AW = 26;

  // Data word, also the controller data width
  localparam int DW = 32;

  // --------------------------------------------------
  // Bus types
  // --------------------------------------------------

  // Address as seen on the bus and in a command
  typedef logic [APP_AW-1:0] wb_addr_t;

  // One data word
  typedef logic [DW-1:0] wb_data_t;

  // Byte selects, active high, one per byte lane
  typedef logic [DW/8-1:0] wb_sel_t;

  // Pending read tracking in the host port
  // RD_IDLE: no read command outstanding
  // RD_WAIT: read command pushed, data not yet delivered
  typedef enum logic {
    RD_IDLE = 1'b0,
    RD_WAIT = 1'b1
  } host_state_e;

endpackage

/* logic/sdr_cmd_pkg.sv */
package sdr_cmd_pkg;

  import wb_bus_pkg::*;

  // --------------------------------------------------
  // Controller side layouts
  // --------------------------------------------------

  // Byte write enables toward the controller, active low
  typedef logic [DW/8-1:0] sdr_mask_t;

  // Command FIFO entry
  // Read flag on top (1 = read), address below
  typedef logic [APP_AW:0] sdr_cmd_t;

  // Write data FIFO entry
  // Byte mask on top, data word below
  typedef logic [DW+DW/8-1:0] sdr_wr_word_t;

  // --------------------------------------------------
  // Default FIFO depths
  // --------------------------------------------------

  // Commands in flight toward the controller
  localparam int CMD_DEPTH_DEF = 4;

  // Write words, deeper so posted writes can stack up
  localparam int WR_DEPTH_DEF = 8;

  // Read words back toward the bus
  localparam int RD_DEPTH_DEF = 4;

endpackage

/* logic/sync_fifo.sv */
`timescale 1ns/100ps

module sync_fifo #(
  parameter int W     = 32,
  parameter int DEPTH = 4
) (
  input  logic         sdram_clk,
  input  logic         wb_rst_n,
  // Write side
  input  logic         push_i,
  input  logic [W-1:0] push_data_i,
  output logic         full_o,
  // Read side, head shown ahead of pop
  input  logic         pop_i,
  output logic [W-1:0] pop_data_o,
  output logic         empty_o
);

  // Pointer width, at least one bit even for a single entry
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  // Occupancy width, must hold DEPTH itself
  localparam int CW = $clog2(DEPTH + 1);
  // Last valid slot, pointers wrap here
  localparam logic [AW-1:0] LAST_IDX = AW'(DEPTH - 1);
  localparam logic [CW-1:0] FULL_CNT = CW'(DEPTH);

  logic [W-1:0]  mem [DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;
  logic          do_push;
  logic          do_pop;

  // --------------------------------------------------
  // Flags and qualified strobes
  // --------------------------------------------------

  // Both flags come straight from the occupancy register
  assign full_o  = (count_q == FULL_CNT);
  assign empty_o = (count_q == '0);

  // Illegal strobes are dropped here as well as flagged below
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Head entry, valid whenever not empty
  assign pop_data_o = mem[rd_ptr_q];

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------

  always_ff @(posedge sdram_clk) begin
    if (do_push) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  // --------------------------------------------------
  // Pointers and occupancy
  // --------------------------------------------------

  always_ff @(posedge sdram_clk) begin
    if (!wb_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Write pointer, wraps after the last slot
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_IDX) ? '0 : wr_ptr_q + AW'(1);
      end
      // Read pointer
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_IDX) ? '0 : rd_ptr_q + AW'(1);
      end
      // Push and pop together leave the count alone
      unique case ({do_push, do_pop})
        2'b10:   count_q <= count_q + CW'(1);
        2'b01:   count_q <= count_q - CW'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  // --------------------------------------------------
  // Producer and consumer contract
  // --------------------------------------------------

  // Producer must watch full
  a_no_overflow: assert property (@(posedge sdram_clk) disable iff (!wb_rst_n)
    push_i |-> !full_o)
    else $error("%m: push while full");

  // Consumer must watch empty
  a_no_underflow: assert property (@(posedge sdram_clk) disable iff (!wb_rst_n)
    pop_i |-> !empty_o)
    else $error("%m: pop while empty");

endmodule

/* logic/wb_host_port.sv */
`timescale 1ns/100ps

module wb_host_port import wb_bus_pkg::*; (
  input  logic sdram_clk,
  input  logic wb_rst_n,
  // Wishbone cycle qualifiers
  input  logic wb_stb_i,
  input  logic wb_cyc_i,
  input  logic wb_we_i,
  output logic wb_ack_o,
  // FIFO status
  input  logic cmd_full_i,
  input  logic wr_full_i,
  input  logic rd_empty_i,
  // FIFO strobes
  output logic cmd_push_o,
  output logic wr_push_o,
  output logic rd_pop_o
);

  host_state_e state_q;
  host_state_e state_d;

  logic bus_valid;
  logic wr_req;
  logic rd_req;
  logic wr_room;
  logic wr_accept;
  logic rd_issue;
  logic rd_ack;

  // --------------------------------------------------
  // Cycle decode
  // --------------------------------------------------

  // Classic cycle only with stb qualified by cyc
  assign bus_valid = wb_stb_i && wb_cyc_i;
  assign wr_req    = bus_valid && wb_we_i;
  assign rd_req    = bus_valid && !wb_we_i;

  // --------------------------------------------------
  // Write path
  // --------------------------------------------------

  // Posted write needs a command slot and a data slot
  assign wr_room   = !cmd_full_i && !wr_full_i;
  assign wr_accept = wr_req && wr_room;

  // --------------------------------------------------
  // Read path
  // --------------------------------------------------

  // One command per read and only from idle
  assign rd_issue = rd_req && (state_q == RD_IDLE) && !cmd_full_i;

  // Data for the outstanding read has landed in the read FIFO
  assign rd_ack = rd_req && (state_q == RD_WAIT) && !rd_empty_i;

  // --------------------------------------------------
  // Outputs
  // --------------------------------------------------

  // Ack is combinational in the same cycle as the deciding condition
  assign wb_ack_o = wr_accept || rd_ack;

  // Command FIFO takes writes and read issues alike
  assign cmd_push_o = wr_accept || rd_issue;

  // Write word goes in with its command
  assign wr_push_o = wr_accept;

  // Read word leaves in the ack cycle
  assign rd_pop_o = rd_ack;

  // --------------------------------------------------
  // Pending read FSM
  // --------------------------------------------------

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      RD_IDLE: begin
        // Command pushed so wait for data
        if (rd_issue) begin
          state_d = RD_WAIT;
        end
      end
      RD_WAIT: begin
        // Data handed to the master
        if (rd_ack) begin
          state_d = RD_IDLE;
        end
      end
      default: state_d = RD_IDLE;
    endcase
  end

  always_ff @(posedge sdram_clk) begin
    if (!wb_rst_n) begin
      state_q <= RD_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------------------------------------
  // Bus protocol checks
  // --------------------------------------------------

  // Read data only ever answers the one outstanding read
  a_rd_data_pending: assert property (@(posedge sdram_clk) disable iff (!wb_rst_n)
    !rd_empty_i |-> (state_q == RD_WAIT))
    else $error("%m: read data with no read pending");

  // Master holds the read until its ack arrives
  a_read_held: assert property (@(posedge sdram_clk) disable iff (!wb_rst_n)
    (state_q == RD_WAIT) |-> wb_stb_i && wb_cyc_i && !wb_we_i)
    else $error("%m: read dropped while pending");

endmodule

/* logic/sdr_bridge_top.sv */
`timescale 1ns/100ps

module sdr_bridge_top import wb_bus_pkg::*, sdr_cmd_pkg::*; #(
  parameter int CMD_DEPTH = CMD_DEPTH_DEF,
  parameter int WR_DEPTH  = WR_DEPTH_DEF,
  parameter int RD_DEPTH  = RD_DEPTH_DEF
) (
  input  logic         sdram_clk,
  input  logic         wb_rst_n,

  // --------------------------------------------------
  // Wishbone slave
  // --------------------------------------------------
  input  logic         wb_stb_i,
  input  logic         wb_cyc_i,
  // 1 = write, 0 = read
  input  logic         wb_we_i,
  input  wb_addr_t     wb_addr_i,
  input  wb_data_t     wb_dat_i,
  input  wb_sel_t      wb_sel_i,
  output logic         wb_ack_o,
  output wb_data_t     wb_dat_o,

  // --------------------------------------------------
  // SDRAM controller handshakes
  // --------------------------------------------------
  // Request, held while a command waits
  output logic         sdr_req_o,
  output wb_addr_t     sdr_req_addr_o,
  // 0 = write, 1 = read
  output logic         sdr_req_wr_n_o,
  // One cycle, pops the command
  input  logic         sdr_req_ack_i,
  // One cycle, pops a write word
  input  logic         sdr_wr_next_i,
  // Active low byte enables for the current write word
  output sdr_mask_t    sdr_wr_en_n_o,
  output wb_data_t     sdr_wr_data_o,
  // One cycle, pushes a read word
  input  logic         sdr_rd_valid_i,
  input  wb_data_t     sdr_rd_data_i
);

  // Host port strobes
  logic         cmd_push;
  logic         wr_push;
  logic         rd_pop;

  // FIFO status
  logic         cmd_full;
  logic         cmd_empty;
  logic         wr_full;
  logic         rd_empty;

  // FIFO entries
  sdr_mask_t    wr_mask;
  sdr_cmd_t     cmd_in;
  sdr_cmd_t     cmd_head;
  sdr_wr_word_t wr_in;
  sdr_wr_word_t wr_head;

  // --------------------------------------------------
  // Bus side control
  // --------------------------------------------------

  wb_host_port u_host_port (
    .sdram_clk  (sdram_clk),
    .wb_rst_n   (wb_rst_n),
    .wb_stb_i   (wb_stb_i),
    .wb_cyc_i   (wb_cyc_i),
    .wb_we_i    (wb_we_i),
    .wb_ack_o   (wb_ack_o),
    .cmd_full_i (cmd_full),
    .wr_full_i  (wr_full),
    .rd_empty_i (rd_empty),
    .cmd_push_o (cmd_push),
    .wr_push_o  (wr_push),
    .rd_pop_o   (rd_pop)
  );

  // --------------------------------------------------
  // Command FIFO
  // --------------------------------------------------

  // Read flag over address, flag is the inverted write enable
  assign cmd_in = {!wb_we_i, wb_addr_i};

  sync_fifo #(
    .W     ($bits(sdr_cmd_t)),
    .DEPTH (CMD_DEPTH)
  ) u_cmd_fifo (
    .sdram_clk   (sdram_clk),
    .wb_rst_n    (wb_rst_n),
    .push_i      (cmd_push),
    .push_data_i (cmd_in),
    .full_o      (cmd_full),
    .pop_i       (sdr_req_ack_i),
    .pop_data_o  (cmd_head),
    .empty_o     (cmd_empty)
  );

  // Any waiting command is a request
  assign sdr_req_o = !cmd_empty;
  assign {sdr_req_wr_n_o, sdr_req_addr_o} = cmd_head;

  // --------------------------------------------------
  // Write data FIFO
  // --------------------------------------------------

  // Controller wants disables, bus gives enables
  assign wr_mask = ~wb_sel_i;
  assign wr_in   = {wr_mask, wb_dat_i};

  // Empty flag unused, controller pops only after a write command
  sync_fifo #(
    .W     ($bits(sdr_wr_word_t)),
    .DEPTH (WR_DEPTH)
  ) u_wr_fifo (
    .sdram_clk   (sdram_clk),
    .wb_rst_n    (wb_rst_n),
    .push_i      (wr_push),
    .push_data_i (wr_in),
    .full_o      (wr_full),
    .pop_i       (sdr_wr_next_i),
    .pop_data_o  (wr_head),
    .empty_o     ()
  );

  assign {sdr_wr_en_n_o, sdr_wr_data_o} = wr_head;

  // --------------------------------------------------
  // Read data FIFO
  // --------------------------------------------------

  // Full flag unused, one read outstanding at most
  sync_fifo #(
    .W     ($bits(wb_data_t)),
    .DEPTH (RD_DEPTH)
  ) u_rd_fifo (
    .sdram_clk   (sdram_clk),
    .wb_rst_n    (wb_rst_n),
    .push_i      (sdr_rd_valid_i),
    .push_data_i (sdr_rd_data_i),
    .full_o      (),
    .pop_i       (rd_pop),
    .pop_data_o  (wb_dat_o),
    .empty_o     (rd_empty)
  );

endmodule

/* verif/sdr_bridge_checks.svh */
`ifndef SDR_BRIDGE_CHECKS_SVH
`define SDR_BRIDGE_CHECKS_SVH

// --------------------------------------------------
// Compare tasks, one per result type
// --------------------------------------------------

// Command address toward the controller
task automatic check_addr(input string name, input wb_addr_t exp, input wb_addr_t act);
  if (act !== exp) begin
    $display("[ERROR] %s: address expected %h, actual %h", name, exp, act);
    err_count++;
  end
endtask

// Data word, bus read data or controller write data
task automatic check_data(input string name, input wb_data_t exp, input wb_data_t act);
  if (act !== exp) begin
    $display("[ERROR] %s: data expected %h, actual %h", name, exp, act);
    err_count++;
  end
endtask

// Active low byte enables
task automatic check_mask(input string name, input sdr_mask_t exp, input sdr_mask_t act);
  if (act !== exp) begin
    $display("[ERROR] %s: byte mask expected %h, actual %h", name, exp, act);
    err_count++;
  end
endtask

// Single control bit, ack, request or read flag
task automatic check_flag(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("[ERROR] %s: flag expected %b, actual %b", name, exp, act);
    err_count++;
  end
endtask

// Failure with no single value to show
task automatic report_fault(input string name, input string what);
  $display("%s: %s", name, what);
  err_count++;
endtask

`endif

/* verif/sdr_bridge_tb.sv */
`timescale 1ns/100ps

module sdr_bridge_tb import wb_bus_pkg::*, sdr_cmd_pkg::*; ();

  // Mid-cycle samples with the controller silent before it is released
  localparam int STALL_CYCLES = 4;

  logic      sdram_clk;
  logic      wb_rst_n;
  logic      wb_stb_i;
  logic      wb_cyc_i;
  logic      wb_we_i;
  wb_addr_t  wb_addr_i;
  wb_data_t  wb_dat_i;
  wb_sel_t   wb_sel_i;
  logic      wb_ack_o;
  wb_data_t  wb_dat_o;
  logic      sdr_req_o;
  wb_addr_t  sdr_req_addr_o;
  logic      sdr_req_wr_n_o;
  logic      sdr_req_ack_i;
  logic      sdr_wr_next_i;
  sdr_mask_t sdr_wr_en_n_o;
  wb_data_t  sdr_wr_data_o;
  logic      sdr_rd_valid_i;
  wb_data_t  sdr_rd_data_i;

  // Trace records, one per data line
  string    rec_name [$];
  string    rec_op   [$];
  wb_addr_t rec_addr [$];
  wb_data_t rec_data [$];
  wb_sel_t  rec_sel  [$];
  int       rec_lat  [$];

  // Commands the controller model still expects, bus order
  logic     exp_rd   [$];
  wb_addr_t exp_addr [$];
  wb_data_t exp_data [$];
  wb_sel_t  exp_sel  [$];
  int       exp_lat  [$];

  string cur_test = "after_reset";
  int    err_count = 0;
  int    cycle_limit = 0;
  logic  hold_ack = 1'b0;
  logic  model_busy = 1'b0;

  `include "sdr_bridge_checks.svh"

  sdr_bridge_top sdr_bridge_top_i (.*);

  initial begin
    sdram_clk = 1'b0;
    forever #5 sdram_clk = ~sdram_clk;
  end

  // --------------------------------------------------
  // Watchdog
  // --------------------------------------------------

  initial begin
    int cycles;
    cycles = 0;
    while (cycle_limit == 0 || cycles < cycle_limit) begin
      @(posedge sdram_clk);
      cycles++;
    end
    $display("Run stopped after %0d cycles, DUT stopped responding", cycles);
    $display("Test failed");
    $finish;
  end

  // Inputs move 1 ns after the edge
  task automatic next_cycle();
    @(posedge sdram_clk);
    #1;
  endtask

  task automatic load_trace();
    int       fd;
    string    line;
    string    name;
    string    op;
    wb_addr_t addr;
    wb_data_t data;
    wb_sel_t  sel;
    int       lat;
    fd = $fopen("verif/sdr_bridge_trace.txt", "r");
    if (fd == 0) begin
      report_fault("trace", "trace file could not be opened");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // Skip comments and blank lines
      if (line.len() < 2 || line.getc(0) == "#") continue;
      if ($sscanf(line, "%s %s %h %h %h %d", name, op, addr, data, sel, lat) == 6) begin
        rec_name.push_back(name);
        rec_op.push_back(op);
        rec_addr.push_back(addr);
        rec_data.push_back(data);
        rec_sel.push_back(sel);
        rec_lat.push_back(lat);
      end
    end
    $fclose(fd);
    if (rec_name.size() == 0) report_fault("trace", "trace file holds no records");
  endtask

  // --------------------------------------------------
  // Bus master
  // --------------------------------------------------

  // Holds one cycle until ack; ends mid cycle in the ack cycle
  task automatic bus_cycle(input logic we, input wb_addr_t addr, input wb_data_t data,
                           input wb_sel_t sel, input int lat, input int release_at,
                           output int waited);
    wb_stb_i  = 1'b1;
    wb_cyc_i  = 1'b1;
    wb_we_i   = we;
    wb_addr_i = addr;
    wb_dat_i  = data;
    wb_sel_i  = sel;
    exp_rd.push_back(!we);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    exp_sel.push_back(sel);
    exp_lat.push_back(lat);
    waited = 0;
    #4;
    while (!wb_ack_o) begin
      // Let the controller answer again
      if (waited == release_at) hold_ack = 1'b0;
      next_cycle();
      waited++;
      #4;
    end
  endtask

  // Idle the bus, then wait out every command of the test
  task automatic drain();
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_we_i  = 1'b0;
    #4;
    while (sdr_req_o || model_busy) begin
      next_cycle();
      #4;
    end
    if (exp_addr.size() != 0) begin
      report_fault(cur_test, "bus cycles left commands that never reached the controller");
      exp_rd.delete();
      exp_addr.delete();
      exp_data.delete();
      exp_sel.delete();
      exp_lat.delete();
    end
    next_cycle();
  endtask

  // --------------------------------------------------
  // SDRAM controller model
  // --------------------------------------------------

  initial begin
    logic     cmd_rd;
    int       lat;
    wb_data_t data;
    wb_sel_t  sel;
    void'($urandom(42101));
    sdr_req_ack_i  = 1'b0;
    sdr_wr_next_i  = 1'b0;
    sdr_rd_valid_i = 1'b0;
    sdr_rd_data_i  = '0;
    forever begin
      next_cycle();
      if (wb_rst_n && sdr_req_o && !hold_ack) begin
        model_busy = 1'b1;
        cmd_rd = sdr_req_wr_n_o;
        data = '0;
        sel = '1;
        lat = 0;
        if (exp_addr.size() == 0) begin
          report_fault(cur_test, "controller got a command no bus cycle asked for");
        end else begin
          data = exp_data.pop_front();
          sel  = exp_sel.pop_front();
          lat  = exp_lat.pop_front();
          check_addr(cur_test, exp_addr.pop_front(), sdr_req_addr_o);
          check_flag(cur_test, exp_rd.pop_front(), sdr_req_wr_n_o);
        end
        // Ack pops the command
        sdr_req_ack_i = 1'b1;
        next_cycle();
        sdr_req_ack_i = 1'b0;
        if (cmd_rd) begin
          repeat (lat) next_cycle();
          sdr_rd_valid_i = 1'b1;
          sdr_rd_data_i  = data;
        end else begin
          // Write word taken after a random gap
          repeat ($urandom_range(3, 0)) next_cycle();
          check_data(cur_test, data, sdr_wr_data_o);
          check_mask(cur_test, ~sel, sdr_wr_en_n_o);
          sdr_wr_next_i = 1'b1;
        end
        next_cycle();
        sdr_rd_valid_i = 1'b0;
        sdr_wr_next_i  = 1'b0;
        model_busy     = 1'b0;
      end
    end
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin
    int idx;
    int k;
    int waited;
    int want;
    int first;
    int tests;
    int failing;
    wb_rst_n  = 1'b0;
    wb_stb_i  = 1'b0;
    wb_cyc_i  = 1'b0;
    wb_we_i   = 1'b0;
    wb_addr_i = '0;
    wb_dat_i  = '0;
    wb_sel_i  = '0;
    tests = 1;
    failing = 0;
    load_trace();
    cycle_limit = 40 * rec_name.size() + 100;
    repeat (8) @(posedge sdram_clk);
    #1;
    wb_rst_n = 1'b1;
    #4;
    // Nothing pending straight out of reset
    check_flag(cur_test, 1'b0, sdr_req_o);
    check_flag(cur_test, 1'b0, wb_ack_o);
    if (err_count != 0) failing++;
    $display("%-14s %s", cur_test, (err_count == 0) ? "PASS" : "FAIL");
    next_cycle();
    idx = 0;
    while (idx < rec_name.size()) begin
      cur_test = rec_name[idx];
      first = err_count;
      // Records sharing a name run back to back
      while (idx < rec_name.size() && rec_name[idx] == cur_test) begin
        if (rec_op[idx] == "S") begin
          #4;
          hold_ack = 1'b1;
          next_cycle();
          // Last write finds the command FIFO full
          for (k = 0; k <= rec_lat[idx]; k++) begin
            want = (k < CMD_DEPTH_DEF) ? 0 : STALL_CYCLES + 2;
            bus_cycle(1'b1, rec_addr[idx] + wb_addr_t'(k), rec_data[idx] + wb_data_t'(k),
                      rec_sel[idx], 0, (k < rec_lat[idx]) ? -1 : STALL_CYCLES, waited);
            if (waited != want) begin
              report_fault(cur_test, $sformatf("write %0d acked after %0d cycles, expected %0d",
                                               k, waited, want));
            end
            next_cycle();
          end
        end else if (rec_op[idx] == "W") begin
          bus_cycle(1'b1, rec_addr[idx], rec_data[idx], rec_sel[idx], 0, -1, waited);
          if (waited != 0) report_fault(cur_test, "write ack came late with room in both FIFOs");
          next_cycle();
        end else if (rec_op[idx] == "R") begin
          bus_cycle(1'b0, rec_addr[idx], rec_data[idx], rec_sel[idx], rec_lat[idx], -1, waited);
          check_data(cur_test, rec_data[idx], wb_dat_o);
          next_cycle();
        end else begin
          report_fault(cur_test, "trace record has an unknown operation");
        end
        idx++;
      end
      drain();
      tests++;
      if (err_count != first) failing++;
      $display("%-14s %s", cur_test, (err_count == first) ? "PASS" : "FAIL");
    end
    $display("%0d tests, %0d failing, %0d errors", tests, failing, err_count);
    if (err_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* sdr_bridge_top.f */
+incdir+verif
logic/wb_bus_pkg.sv
logic/sdr_cmd_pkg.sv
logic/sync_fifo.sv
logic/wb_host_port.sv
logic/sdr_bridge_top.sv
verif/sdr_bridge_tb.sv

/* verif/sdr_bridge_trace.txt */
# name          op addr    data     sel lat
# op W write, R read, S stall (lat = requests left unanswered); hex fields, lat in cycles
write_full      W 0000100 a5a5a5a5 f   0
write_lanes     W 0000104 12345678 5   0
write_lanes     W 3ffffff 0badcafe 8   0
read_short      R 0000100 deadbeef f   0
read_long       R 0000200 c001d00d f   9
wr_then_rd      W 0000300 11112222 3   0
wr_then_rd      R 0000304 33334444 f   2
wr_then_rd      W 0000308 55556666 c   0
wr_then_rd      R 000030c 77778888 f   5
back_pressure   S 0000400 90000000 f   4
read_after_bp   R 0000500 feedf00d f   1
